// File: Makefile
# Verilator build for the pooling slice testbench
# every variable can be overridden, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= pool_tb
FILELIST  ?= pool.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= ALL CHECKS PASSED

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: compile
	$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: common/pool_macros.svh
`ifndef POOL_MACROS_SVH
`define POOL_MACROS_SVH

// --------------------
// datapath widths
`define POOL_WORD_W      32           // two packed samples per pipe word
`define POOL_SAMPLE_W    16
`define POOL_ACC_W       19           // holds a sum of 8 samples
`define POOL_OPNUM_W     16
`define POOL_SHIFT_W     2
`define POOL_ADDR_W      8

// --------------------
// pipe FIFOs and block throttle
`define POOL_FIFO_AW     6
`define POOL_FIFO_DEPTH  (1 << `POOL_FIFO_AW)
`define POOL_BLOCK_SIZE  16           // words per host block
`define POOL_HEADROOM    4            // slack for the registered ready flag

// --------------------
// APB register map
`define POOL_ADDR_CTRL   8'h00
`define POOL_ADDR_OPNUM  8'h04
`define POOL_ADDR_STATUS 8'h08
`define POOL_ADDR_IRQEN  8'h0C

`endif

// File: common/pool_pkg.sv
`default_nettype none

`include "pool_macros.svh"

package pool_pkg;

	// --------------------
	// data words and samples
	typedef logic [`POOL_WORD_W-1:0] word_t;            // lane 0 in the low half
	typedef logic signed [`POOL_SAMPLE_W-1:0] sample_t;
	typedef logic signed [`POOL_ACC_W-1:0] acc_t;       // per-lane max or running sum

	// --------------------
	// control values
	typedef logic [`POOL_FIFO_AW:0] count_t;            // 0 up to full depth
	typedef logic [`POOL_OPNUM_W-1:0] op_num_t;         // windows per run
	typedef logic [`POOL_SHIFT_W-1:0] shift_t;          // log2 of window length
	typedef logic [`POOL_ADDR_W-1:0] apb_addr_t;

	typedef enum logic {
		OP_MAX = 1'b0,
		OP_AVE = 1'b1
	} op_type_e;

	typedef enum logic [1:0] {
		ST_IDLE  = 2'd0,
		ST_ACCUM = 2'd1,
		ST_EMIT  = 2'd2
	} engine_state_e;

endpackage

`default_nettype wire

// File: dv/pool_assertions.sv
`default_nettype none

module pool_assertions
	import pool_pkg::*;
(
	input  wire   okClk,
	input  wire   reset,
	input  wire   psel,
	input  wire   penable,
	input  wire   pready,
	input  wire   pslverr,
	input  wire   pipe_out_read,
	input  wire   pipe_out_ready,
	input  word_t pipe_out_data
);

	// --------------------
	// APB access phase
	a_pslverr_in_access: assert property (@(posedge okClk) disable iff (reset)
		pslverr |-> (psel && penable))
		else $error("pslverr raised outside an APB access phase");

	a_pready_in_access: assert property (@(posedge okClk) disable iff (reset)
		(psel && penable) |-> pready)
		else $error("pready low during an APB access phase");

	// --------------------
	// pipe out
	a_out_data_known: assert property (@(posedge okClk) disable iff (reset)
		(pipe_out_read && pipe_out_ready) |-> !$isunknown(pipe_out_data))
		else $error("pipe_out_data unknown while a full block is being read");

endmodule

`default_nettype wire

// File: dv/pool_tb.sv
`default_nettype none

`include "pool_macros.svh"

module pool_tb
	import pool_pkg::*;
();

	localparam int CLK_PERIOD = 40;
	localparam int DRIVE_DLY  = 2;     // inputs change this long after the rising edge
	localparam int SAMPLE_DLY = 5;
	localparam int DONE_POLLS = 300;
	// cycle budget of each test in run order
	localparam int BUDGET_CYCLES = 300 + 400 + 400 + 800 + 200 + 800;
	localparam int WATCHDOG_TIME = (BUDGET_CYCLES + 20) * CLK_PERIOD;

	logic okClk;
	logic reset;
	logic psel;
	logic penable;
	logic pwrite;
	apb_addr_t paddr;
	word_t pwdata;
	word_t prdata;
	logic pready;
	logic pslverr;
	logic pipe_in_write;
	word_t pipe_in_data;
	logic pipe_in_ready;
	logic pipe_out_read;
	word_t pipe_out_data;
	logic pipe_out_ready;
	logic irq;

	word_t in_q[$];            // pushed words the engine has not pooled yet
	logic [31:0] rng_state;

	pool_top u_pool_top (
		.okClk          (okClk),
		.reset          (reset),
		.psel           (psel),
		.penable        (penable),
		.pwrite         (pwrite),
		.paddr          (paddr),
		.pwdata         (pwdata),
		.prdata         (prdata),
		.pready         (pready),
		.pslverr        (pslverr),
		.pipe_in_write  (pipe_in_write),
		.pipe_in_data   (pipe_in_data),
		.pipe_in_ready  (pipe_in_ready),
		.pipe_out_read  (pipe_out_read),
		.pipe_out_data  (pipe_out_data),
		.pipe_out_ready (pipe_out_ready),
		.irq            (irq)
	);

	bind pool_top pool_assertions u_assertions (
		.okClk          (okClk),
		.reset          (reset),
		.psel           (psel),
		.penable        (penable),
		.pready         (pready),
		.pslverr        (pslverr),
		.pipe_out_read  (pipe_out_read),
		.pipe_out_ready (pipe_out_ready),
		.pipe_out_data  (pipe_out_data)
	);

	initial begin
		okClk = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) okClk = ~okClk;
		end
	end

	// --------------------
	// failure handling and compares
	task automatic stop_failed();
		$display("CHECKS FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("MISMATCH time=%0t %s got=%h expected=%h", $time, name, got, exp);
			stop_failed();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("MISMATCH time=%0t %s got=%b expected=%b", $time, name, got, exp);
			stop_failed();
		end
	endtask

	task automatic check_count(input string name, input op_num_t got, input op_num_t exp);
		if (got !== exp) begin
			$display("MISMATCH time=%0t %s got=%0d expected=%0d", $time, name, got, exp);
			stop_failed();
		end
	endtask

	// --------------------
	// stimulus helpers
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic rand_word(output word_t w);
		rng_state = xorshift32(rng_state);
		w = rng_state;
	endtask

	task automatic next_edge();
		@(posedge okClk);
		#(DRIVE_DLY);
	endtask

	task automatic apb_write(input apb_addr_t addr, input word_t data, input logic exp_err);
		psel   = 1'b1;
		pwrite = 1'b1;
		paddr  = addr;
		pwdata = data;
		next_edge();
		penable = 1'b1;    // access phase with the write landing on the next edge
		#(SAMPLE_DLY);
		check_bit("pslverr", pslverr, exp_err);
		next_edge();
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_read(input apb_addr_t addr, output word_t data, input logic exp_err);
		psel   = 1'b1;
		pwrite = 1'b0;
		paddr  = addr;
		next_edge();
		penable = 1'b1;
		#(SAMPLE_DLY);
		data = prdata;
		check_bit("pslverr", pslverr, exp_err);
		next_edge();
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic expect_reg(input string name, input apb_addr_t addr, input word_t exp);
		word_t rd;
		apb_read(addr, rd, 1'b0);
		check_word(name, rd, exp);
	endtask

	task automatic push_word(input word_t w, input logic keep);
		pipe_in_data  = w;
		pipe_in_write = 1'b1;
		next_edge();
		pipe_in_write = 1'b0;
		if (keep) begin
			in_q.push_back(w);
		end
	endtask

	task automatic push_random(input int n);
		word_t w;
		for (int i = 0; i < n; i++) begin
			rand_word(w);
			push_word(w, 1'b1);
		end
	endtask

	task automatic pop_word(output word_t w);
		w = pipe_out_data;    // show-ahead head
		pipe_out_read = 1'b1;
		next_edge();
		pipe_out_read = 1'b0;
	endtask

	task automatic start_run(input op_type_e op, input shift_t sh, input op_num_t n);
		apb_write(`POOL_ADDR_OPNUM, {16'd0, n}, 1'b0);
		apb_write(`POOL_ADDR_CTRL, {28'd0, sh, op, 1'b1}, 1'b0);
	endtask

	task automatic wait_done();
		word_t st;
		int polls;
		st = '0;
		polls = 0;
		while (st[1] !== 1'b1) begin
			if (polls >= DONE_POLLS) begin
				$display("timeout: the engine never reported done");
				stop_failed();
			end else begin
				apb_read(`POOL_ADDR_STATUS, st, 1'b0);
				polls++;
			end
		end
		check_bit("STATUS.busy", st[0], 1'b0);
	endtask

	task automatic clear_done();
		apb_write(`POOL_ADDR_STATUS, 32'h2, 1'b0);
	endtask

	// --------------------
	// reference model
	function automatic int lane_value(input word_t w, input int lane);
		sample_t s;
		s = w[lane*16 +: 16];
		return int'(s);
	endfunction

	// division that rounds toward minus infinity
	function automatic int floor_div(input int num, input int den);
		int q;
		q = num / den;
		if ((num % den) != 0 && num < 0) begin
			q = q - 1;
		end
		return q;
	endfunction

	task automatic expect_window(input op_type_e op, input shift_t sh, output word_t exp);
		int len;
		int res0;
		int res1;
		word_t w;
		len  = 1 << sh;
		res0 = 0;
		res1 = 0;
		for (int i = 0; i < len; i++) begin
			w = in_q.pop_front();
			if (i == 0) begin
				res0 = lane_value(w, 0);
				res1 = lane_value(w, 1);
			end else if (op == OP_MAX) begin
				res0 = (lane_value(w, 0) > res0) ? lane_value(w, 0) : res0;
				res1 = (lane_value(w, 1) > res1) ? lane_value(w, 1) : res1;
			end else begin
				res0 += lane_value(w, 0);
				res1 += lane_value(w, 1);
			end
		end
		if (op == OP_AVE) begin
			res0 = floor_div(res0, len);
			res1 = floor_div(res1, len);
		end
		exp = {res1[15:0], res0[15:0]};
	endtask

	task automatic drain_and_check(input op_type_e op, input shift_t sh, input int n);
		word_t exp;
		word_t got;
		for (int i = 0; i < n; i++) begin
			expect_window(op, sh, exp);
			pop_word(got);
			check_word("pipe_out_data", got, exp);
		end
	endtask

	// --------------------
	// directed tests
	task automatic test_registers();
		word_t rd;
		expect_reg("CTRL", `POOL_ADDR_CTRL, '0);
		expect_reg("OPNUM", `POOL_ADDR_OPNUM, '0);
		expect_reg("STATUS", `POOL_ADDR_STATUS, '0);
		expect_reg("IRQEN", `POOL_ADDR_IRQEN, '0);
		apb_write(`POOL_ADDR_CTRL, 32'h0000_000E, 1'b0);    // ave, shift 3, no start
		apb_write(`POOL_ADDR_OPNUM, 32'hABCD_1234, 1'b0);
		apb_write(`POOL_ADDR_IRQEN, 32'h1, 1'b0);
		expect_reg("CTRL", `POOL_ADDR_CTRL, 32'h0000_000E);
		apb_read(`POOL_ADDR_OPNUM, rd, 1'b0);
		check_count("OPNUM.op_num", rd[15:0], 16'h1234);
		check_word("OPNUM", rd, 32'h0000_1234);
		expect_reg("IRQEN", `POOL_ADDR_IRQEN, 32'h1);
		check_bit("irq", irq, 1'b0);
		apb_write(8'h10, 32'hFFFF_FFFF, 1'b1);    // unmapped
		apb_read(8'h14, rd, 1'b1);
		expect_reg("CTRL", `POOL_ADDR_CTRL, 32'h0000_000E);
		expect_reg("OPNUM", `POOL_ADDR_OPNUM, 32'h0000_1234);
		expect_reg("STATUS", `POOL_ADDR_STATUS, '0);
		expect_reg("IRQEN", `POOL_ADDR_IRQEN, 32'h1);
		apb_write(`POOL_ADDR_CTRL, '0, 1'b0);
		apb_write(`POOL_ADDR_OPNUM, '0, 1'b0);
		apb_write(`POOL_ADDR_IRQEN, '0, 1'b0);
	endtask

	task automatic test_max_pool();
		start_run(OP_MAX, 2'd2, 16'd5);    // engine waits on the empty pipe
		push_random(20);
		wait_done();
		clear_done();
		drain_and_check(OP_MAX, 2'd2, 5);
	endtask

	task automatic test_ave_pool();
		start_run(OP_AVE, 2'd3, 16'd3);
		for (int i = 0; i < 8; i++) begin
			push_word(32'h8000_7FFF, 1'b1);    // lane extremes
		end
		push_random(16);
		wait_done();
		clear_done();
		drain_and_check(OP_AVE, 2'd3, 3);
		start_run(OP_MAX, 2'd0, 16'd0);
		wait_done();
		check_count("out_count", op_num_t'(u_pool_top.out_count), '0);
		clear_done();
	endtask

	task automatic test_throttle();
		word_t exp;
		word_t got;
		next_edge();
		check_bit("pipe_in_ready", pipe_in_ready, 1'b1);
		for (int k = 0; k < 45; k++) begin
			push_random(1);
			check_bit("pipe_in_ready", pipe_in_ready, 1'b1);
		end
		next_edge();
		check_bit("pipe_in_ready", pipe_in_ready, 1'b0);
		check_bit("pipe_out_ready", pipe_out_ready, 1'b0);
		start_run(OP_MAX, 2'd0, 16'd16);
		wait_done();
		clear_done();
		check_bit("pipe_out_ready", pipe_out_ready, 1'b1);
		expect_window(OP_MAX, 2'd0, exp);
		pop_word(got);
		check_word("pipe_out_data", got, exp);
		check_bit("pipe_out_ready", pipe_out_ready, 1'b1);
		next_edge();
		check_bit("pipe_out_ready", pipe_out_ready, 1'b0);
		drain_and_check(OP_MAX, 2'd0, 15);
		check_bit("pipe_in_ready", pipe_in_ready, 1'b1);    // 29 words left
		start_run(OP_MAX, 2'd0, 16'd29);
		wait_done();
		clear_done();
		drain_and_check(OP_MAX, 2'd0, 29);
	endtask

	task automatic test_irq();
		apb_write(`POOL_ADDR_IRQEN, '0, 1'b0);
		start_run(OP_MAX, 2'd0, 16'd0);
		wait_done();
		check_bit("irq", irq, 1'b0);
		apb_write(`POOL_ADDR_IRQEN, 32'h1, 1'b0);
		check_bit("irq", irq, 1'b1);
		clear_done();
		check_bit("irq", irq, 1'b0);
		expect_reg("STATUS", `POOL_ADDR_STATUS, '0);
		apb_write(`POOL_ADDR_IRQEN, '0, 1'b0);
	endtask

	task automatic test_overflow();
		word_t extra;
		push_random(64);
		expect_reg("STATUS", `POOL_ADDR_STATUS, '0);
		rand_word(extra);
		push_word(extra, 1'b0);    // dropped by the full FIFO
		expect_reg("STATUS", `POOL_ADDR_STATUS, 32'h4);
		start_run(OP_MAX, 2'd0, 16'd64);
		wait_done();
		clear_done();
		expect_reg("STATUS", `POOL_ADDR_STATUS, 32'h4);
		apb_write(`POOL_ADDR_STATUS, 32'h4, 1'b0);
		expect_reg("STATUS", `POOL_ADDR_STATUS, '0);
		drain_and_check(OP_MAX, 2'd0, 64);
	endtask

	// --------------------
	// main sequence and watchdog
	initial begin
		reset         = 1'b1;
		psel          = 1'b0;
		penable       = 1'b0;
		pwrite        = 1'b0;
		paddr         = '0;
		pwdata        = '0;
		pipe_in_write = 1'b0;
		pipe_in_data  = '0;
		pipe_out_read = 1'b0;
		rng_state     = 32'h0b6ddc3a;
		repeat (2) @(posedge okClk);
		#(DRIVE_DLY);
		reset = 1'b0;
		test_registers();
		test_max_pool();
		test_ave_pool();
		test_throttle();
		test_irq();
		test_overflow();
		$display("ALL CHECKS PASSED");
		$finish;
	end

	initial begin
		#(WATCHDOG_TIME);
		$display("watchdog: the tests ran past their time budget");
		stop_failed();
	end

endmodule

`default_nettype wire

// File: pool.f
+incdir+common
common/pool_pkg.sv
verilog/fifo_sync.sv
verilog/block_throttle.sv
verilog/csb_regs.sv
pool_engine/pool_engine.sv
verilog/pool_top.sv
dv/pool_assertions.sv
dv/pool_tb.sv

// File: pool_engine/pool_engine.sv
`default_nettype none

module pool_engine
	import pool_pkg::*;
(
	input  wire      okClk,
	input  wire      reset,
	input  wire      start,
	input  op_type_e op_type,
	input  shift_t   pool_shift,
	input  op_num_t  op_num,
	input  word_t    in_data,
	input  wire      in_empty,
	input  wire      out_full,
	output logic     in_rd_en,
	output logic     out_wr_en,
	output word_t    out_data,
	output logic     busy,
	output logic     done_pulse
);

	engine_state_e state_q;
	op_type_e type_q;
	shift_t shift_q;
	op_num_t remain_q;
	logic [2:0] beat_q;
	logic first_beat;
	logic last_beat;
	acc_t acc0_q;
	acc_t acc1_q;

	// first word of a window loads, later words fold in
	function automatic acc_t lane_update(input acc_t acc, input sample_t s,
			input logic first, input op_type_e op);
		acc_t ext;
		ext = acc_t'(s);    // sign extend
		if (first) begin
			return ext;
		end
		if (op == OP_MAX) begin
			return (ext > acc) ? ext : acc;
		end
		return acc + ext;
	endfunction

	// average is the arithmetic shift of the sum, so it rounds toward minus infinity
	function automatic sample_t lane_result(input acc_t acc, input op_type_e op,
			input shift_t sh);
		acc_t scaled;
		scaled = acc >>> sh;
		if (op == OP_AVE) begin
			return sample_t'(scaled);
		end
		return sample_t'(acc);
	endfunction

	// --------------------
	// handshakes
	assign in_rd_en   = (state_q == ST_ACCUM) & ~in_empty;
	assign out_wr_en  = (state_q == ST_EMIT) & ~out_full;
	assign busy       = (state_q != ST_IDLE);
	assign first_beat = (beat_q == '0);
	assign last_beat  = (({1'b0, beat_q} + 4'd1) == (4'd1 << shift_q));

	assign out_data = {lane_result(acc1_q, type_q, shift_q),
			lane_result(acc0_q, type_q, shift_q)};

	// --------------------
	// FSM
	always_ff @(posedge okClk) begin
		if (reset) begin
			state_q    <= ST_IDLE;
			remain_q   <= '0;
			beat_q     <= '0;
			done_pulse <= 1'b0;
		end else begin
			done_pulse <= 1'b0;
			case (state_q)
				ST_IDLE: begin
					if (start) begin
						remain_q <= op_num;
						beat_q   <= '0;
						if (op_num == '0) begin
							done_pulse <= 1'b1;    // empty run finishes at once
						end else begin
							state_q <= ST_ACCUM;
						end
					end
				end
				ST_ACCUM: begin
					if (in_rd_en) begin
						if (last_beat) begin
							beat_q  <= '0;
							state_q <= ST_EMIT;
						end else begin
							beat_q <= beat_q + 1'b1;
						end
					end
				end
				ST_EMIT: begin
					if (out_wr_en) begin
						remain_q <= remain_q - 1'b1;
						if (remain_q == op_num_t'(1)) begin
							state_q    <= ST_IDLE;
							done_pulse <= 1'b1;    // last result went out
						end else begin
							state_q <= ST_ACCUM;
						end
					end
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	// --------------------
	// run config and lane accumulators
	always_ff @(posedge okClk) begin
		if (state_q == ST_IDLE && start) begin
			type_q  <= op_type;
			shift_q <= pool_shift;
		end
		if (in_rd_en) begin
			acc0_q <= lane_update(acc0_q, sample_t'(in_data[15:0]), first_beat, type_q);
			acc1_q <= lane_update(acc1_q, sample_t'(in_data[31:16]), first_beat, type_q);
		end
	end

endmodule

`default_nettype wire

// File: verilog/block_throttle.sv
`default_nettype none

`include "pool_macros.svh"

module block_throttle
	import pool_pkg::*;
(
	input  wire    okClk,
	input  wire    reset,
	input  count_t in_count,
	input  count_t out_count,
	output logic   pipe_in_ready,
	output logic   pipe_out_ready
);

	localparam int IN_LIMIT = `POOL_FIFO_DEPTH - `POOL_HEADROOM - `POOL_BLOCK_SIZE;

	logic in_room;
	logic out_block;

	// host may push a whole block only with headroom left over
	assign in_room   = (int'(in_count) <= IN_LIMIT);
	assign out_block = (int'(out_count) >= `POOL_BLOCK_SIZE);    // a full block to drain

	// --------------------
	// one cycle behind the counts
	always_ff @(posedge okClk) begin
		if (reset) begin
			pipe_in_ready  <= 1'b0;
			pipe_out_ready <= 1'b0;
		end else begin
			pipe_in_ready  <= in_room;
			pipe_out_ready <= out_block;
		end
	end

endmodule

`default_nettype wire

// File: verilog/csb_regs.sv
`default_nettype none

`include "pool_macros.svh"

module csb_regs
	import pool_pkg::*;
(
	input  wire       okClk,
	input  wire       reset,
	input  wire       psel,
	input  wire       penable,
	input  wire       pwrite,
	input  apb_addr_t paddr,
	input  word_t     pwdata,
	input  wire       engine_busy,
	input  wire       engine_done,
	input  wire       in_overflow,
	output word_t     prdata,
	output logic      pready,
	output logic      pslverr,
	output logic      start,
	output op_type_e  op_type,
	output shift_t    pool_shift,
	output op_num_t   op_num,
	output logic      irq
);

	logic access;
	logic hit_ctrl;
	logic hit_opnum;
	logic hit_status;
	logic hit_irqen;
	logic wr;
	logic busy_rd;
	logic done_q;
	logic ovf_q;
	logic irq_en_q;

	// --------------------
	// APB decode
	assign access     = psel & penable;
	assign hit_ctrl   = (paddr == `POOL_ADDR_CTRL);
	assign hit_opnum  = (paddr == `POOL_ADDR_OPNUM);
	assign hit_status = (paddr == `POOL_ADDR_STATUS);
	assign hit_irqen  = (paddr == `POOL_ADDR_IRQEN);
	assign wr         = access & pwrite;

	assign pready  = 1'b1;    // zero wait states
	assign pslverr = access & ~(hit_ctrl | hit_opnum | hit_status | hit_irqen);

	// start already issued counts as busy
	assign busy_rd = engine_busy | start;
	assign irq     = done_q & irq_en_q;

	always_comb begin
		prdata = '0;
		if (access) begin
			case (paddr)
				`POOL_ADDR_CTRL:   prdata = {28'd0, pool_shift, op_type, busy_rd};
				`POOL_ADDR_OPNUM:  prdata = {16'd0, op_num};
				`POOL_ADDR_STATUS: prdata = {29'd0, ovf_q, done_q, busy_rd};
				`POOL_ADDR_IRQEN:  prdata = {31'd0, irq_en_q};
				default:           prdata = '0;
			endcase
		end
	end

	// --------------------
	// configuration and start
	always_ff @(posedge okClk) begin
		if (reset) begin
			op_type    <= OP_MAX;
			pool_shift <= '0;
			op_num     <= '0;
			irq_en_q   <= 1'b0;
			start      <= 1'b0;
		end else begin
			start <= wr & hit_ctrl & pwdata[0] & ~busy_rd;    // single-cycle pulse
			if (wr && hit_ctrl) begin
				op_type    <= op_type_e'(pwdata[1]);
				pool_shift <= pwdata[3:2];
			end
			if (wr && hit_opnum) begin
				op_num <= pwdata[15:0];
			end
			if (wr && hit_irqen) begin
				irq_en_q <= pwdata[0];
			end
		end
	end

	// a new event wins over a clear of a sticky flag
	always_ff @(posedge okClk) begin
		if (reset) begin
			done_q <= 1'b0;
			ovf_q  <= 1'b0;
		end else begin
			if (engine_done) begin
				done_q <= 1'b1;
			end else if (wr && hit_status && pwdata[1]) begin
				done_q <= 1'b0;
			end
			if (in_overflow) begin
				ovf_q <= 1'b1;
			end else if (wr && hit_status && pwdata[2]) begin
				ovf_q <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/fifo_sync.sv
`default_nettype none

`include "pool_macros.svh"

module fifo_sync
	import pool_pkg::*;
#(
	parameter int AW = `POOL_FIFO_AW
) (
	input  wire    okClk,
	input  wire    reset,
	input  wire    wr_en,
	input  word_t  din,
	input  wire    rd_en,
	output word_t  dout,
	output logic   full,
	output logic   empty,
	output count_t count
);

	localparam int DEPTH = 1 << AW;

	word_t mem [DEPTH];
	logic [AW-1:0] wr_ptr_q;
	logic [AW-1:0] rd_ptr_q;
	count_t cnt_q;
	logic wr_ok;
	logic rd_ok;

	assign full  = (cnt_q == count_t'(DEPTH));
	assign empty = (cnt_q == '0);
	assign count = cnt_q;
	assign dout  = mem[rd_ptr_q];    // show-ahead head entry

	assign wr_ok = wr_en & ~full;    // writes into a full FIFO are lost
	assign rd_ok = rd_en & ~empty;

	// storage
	always_ff @(posedge okClk) begin
		if (wr_ok) begin
			mem[wr_ptr_q] <= din;
		end
	end

	// --------------------
	// pointers and occupancy
	always_ff @(posedge okClk) begin
		if (reset) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			cnt_q    <= '0;
		end else begin
			if (wr_ok) begin
				wr_ptr_q <= wr_ptr_q + 1'b1;    // wraps at depth
			end
			if (rd_ok) begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
			case ({wr_ok, rd_ok})
				2'b10:   cnt_q <= cnt_q + 1'b1;
				2'b01:   cnt_q <= cnt_q - 1'b1;
				default: cnt_q <= cnt_q;    // both or neither
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verilog/pool_top.sv
`default_nettype none

module pool_top
	import pool_pkg::*;
(
	input  wire       okClk,
	input  wire       reset,
	// APB slave
	input  wire       psel,
	input  wire       penable,
	input  wire       pwrite,
	input  apb_addr_t paddr,
	input  word_t     pwdata,
	output word_t     prdata,
	output logic      pready,
	output logic      pslverr,
	// host pipes
	input  wire       pipe_in_write,
	input  word_t     pipe_in_data,
	output logic      pipe_in_ready,
	input  wire       pipe_out_read,
	output word_t     pipe_out_data,
	output logic      pipe_out_ready,
	output logic      irq
);

	word_t in_data;
	word_t out_data;
	logic in_rd_en;
	logic in_full;
	logic in_empty;
	logic out_wr_en;
	logic out_full;
	count_t in_count;
	count_t out_count;
	logic in_overflow;
	logic start;
	op_type_e op_type;
	shift_t pool_shift;
	op_num_t op_num;
	logic engine_busy;
	logic engine_done;

	assign in_overflow = pipe_in_write & in_full;    // host pushed into a full FIFO

	// --------------------
	// pipe FIFOs
	fifo_sync u_pipe_in_fifo (
		.okClk (okClk),
		.reset (reset),
		.wr_en (pipe_in_write),
		.din   (pipe_in_data),
		.rd_en (in_rd_en),
		.dout  (in_data),
		.full  (in_full),
		.empty (in_empty),
		.count (in_count)
	);

	fifo_sync u_pipe_out_fifo (
		.okClk (okClk),
		.reset (reset),
		.wr_en (out_wr_en),
		.din   (out_data),
		.rd_en (pipe_out_read),
		.dout  (pipe_out_data),
		.full  (out_full),
		.empty (),    // host reads are gated by the FIFO itself
		.count (out_count)
	);

	block_throttle u_throttle (
		.okClk          (okClk),
		.reset          (reset),
		.in_count       (in_count),
		.out_count      (out_count),
		.pipe_in_ready  (pipe_in_ready),
		.pipe_out_ready (pipe_out_ready)
	);

	// --------------------
	// control and engine
	csb_regs u_csb (
		.okClk       (okClk),
		.reset       (reset),
		.psel        (psel),
		.penable     (penable),
		.pwrite      (pwrite),
		.paddr       (paddr),
		.pwdata      (pwdata),
		.engine_busy (engine_busy),
		.engine_done (engine_done),
		.in_overflow (in_overflow),
		.prdata      (prdata),
		.pready      (pready),
		.pslverr     (pslverr),
		.start       (start),
		.op_type     (op_type),
		.pool_shift  (pool_shift),
		.op_num      (op_num),
		.irq         (irq)
	);

	pool_engine u_engine (
		.okClk      (okClk),
		.reset      (reset),
		.start      (start),
		.op_type    (op_type),
		.pool_shift (pool_shift),
		.op_num     (op_num),
		.in_data    (in_data),
		.in_empty   (in_empty),
		.out_full   (out_full),
		.in_rd_en   (in_rd_en),
		.out_wr_en  (out_wr_en),
		.out_data   (out_data),
		.busy       (engine_busy),
		.done_pulse (engine_done)
	);

endmodule

`default_nettype wire
